/* hdl/soc_bus_pkg.sv */
package soc_bus_pkg;

    // bus widths
    localparam int addr_w = 64;
    localparam int data_w = 64;

    // on-chip RAM, 32-bit words
    localparam logic [addr_w-1:0] ram_base = 64'h0000_0000_0000_1000;
    localparam int ram_words = 256;
    localparam int ram_bytes = ram_words * 4;
    localparam int ram_idx_w = $clog2(ram_words);

    // interrupt controller window
    localparam logic [addr_w-1:0] plic_base = 64'h0000_0000_0C00_0000;
    localparam logic [addr_w-1:0] plic_size = 64'h0000_0000_0040_0000;

    // register offsets from plic_base
    // priority words start at offset 0, one per id
    localparam logic [addr_w-1:0] plic_pending_off = 64'h1000;
    localparam logic [addr_w-1:0] plic_enable_off = 64'h2000;
    localparam logic [addr_w-1:0] plic_enable_step = 64'h80;
    localparam logic [addr_w-1:0] plic_threshold_off = 64'h20_0000;
    localparam logic [addr_w-1:0] plic_threshold_step = 64'h1000;
    // claim sits next to the threshold of each context
    localparam logic [addr_w-1:0] plic_claim_off = 64'h4;

    // sources use ids 1 to 5, id 0 is none
    localparam int plic_sources = 5;
    localparam int plic_contexts = 2;
    localparam int prio_w = 3;
    localparam int plic_id_w = $clog2(plic_sources + 1);

    // size field codes, shared by loads and stores
    localparam logic [1:0] sz_byte = 2'b00;
    localparam logic [1:0] sz_half = 2'b01;
    localparam logic [1:0] sz_word = 2'b10;

    // raw code of the double access (ld / sd)
    localparam logic [2:0] ls_ld = 3'b011;

    // struct view: top bit is the unsigned flag
    typedef struct packed {
        logic       is_unsigned;
        logic [1:0] size;
    } ls_fields_t;

    // access type word
    // raw: 000 lb, 001 lh, 010 lw, 011 ld, 100 lbu, 101 lhu, 110 lwu
    typedef union packed {
        logic [2:0] raw;
        ls_fields_t f;
    } ls_type_u;

endpackage

/* hdl/bus_target_if.sv */
interface bus_target_if;
    import soc_bus_pkg::*;

    // request side, driven by the responder
    logic              sel;
    logic              rd_go;
    logic              wr_go;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    ls_type_u          ls_type;

    // result side, driven by the target
    logic [data_w-1:0] rdata;
    logic              ack;

    modport responder (
        output sel, rd_go, wr_go, addr, wdata, ls_type,
        input  rdata, ack
    );

    // addr arrives as an offset from the target base
    modport target (
        input  sel, rd_go, wr_go, addr, wdata, ls_type,
        output rdata, ack
    );

endinterface

/* hdl/ram_port.sv */
module ram_port (
    input logic          CLOCK_50,
    input logic          KEY0,
    bus_target_if.target bus
);
    import soc_bus_pkg::*;

    logic [31:0] mem [ram_words];

    // second beat of ld / sd
    logic beat;
    // low word of ld, held across the first beat
    logic [31:0] lo_word;

    logic [ram_idx_w-1:0] idx;
    logic [ram_idx_w-1:0] nxt_idx;
    logic [ram_idx_w-1:0] wr_idx;
    logic                 dbl;
    logic                 act;
    logic [31:0]          rd_shift;
    logic [31:0]          wr_word;
    logic                 sgn;

    assign idx = bus.addr[ram_idx_w+1:2];
    assign nxt_idx = idx + 1'b1;

    // double access recognized on the raw code
    assign dbl = (bus.ls_type.raw == ls_ld);
    assign act = bus.sel && (bus.rd_go || bus.wr_go);

    // single beat unless double
    assign bus.ack = act && (!dbl || beat);

    // move the addressed lane down to bit 0
    assign rd_shift = mem[idx] >> {bus.addr[1:0], 3'b000};
    assign sgn = !bus.ls_type.f.is_unsigned;

    // load extension
    always_comb begin
        if (dbl) begin
            bus.rdata = {mem[nxt_idx], lo_word};
        end else begin
            case (bus.ls_type.f.size)
                sz_byte: bus.rdata = {{56{sgn & rd_shift[7]}}, rd_shift[7:0]};
                sz_half: bus.rdata = {{48{sgn & rd_shift[15]}}, rd_shift[15:0]};
                default: bus.rdata = {{32{sgn & rd_shift[31]}}, rd_shift[31:0]};
            endcase
        end
    end

    // byte lane merge into the stored word
    always_comb begin
        wr_word = mem[idx];
        wr_idx = idx;
        case (bus.ls_type.f.size)
            sz_byte: wr_word[{bus.addr[1:0], 3'b000} +: 8] = bus.wdata[7:0];
            sz_half: wr_word[{bus.addr[1], 4'b0000} +: 16] = bus.wdata[15:0];
            sz_word: wr_word = bus.wdata[31:0];
            default: begin
                // sd, low word first then high word
                wr_word = beat ? bus.wdata[63:32] : bus.wdata[31:0];
                wr_idx = beat ? nxt_idx : idx;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50) begin
        if (bus.sel && bus.wr_go) begin
            mem[wr_idx] <= wr_word;
        end
        // first ld beat keeps the low word
        if (bus.sel && bus.rd_go && dbl && !beat) begin
            lo_word <= mem[idx];
        end
    end

    // beat toggles on each double step
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            beat <= 1'b0;
        end else if (act && dbl) begin
            beat <= !beat;
        end
    end

endmodule

/* hdl/plic_regs.sv */
module plic_regs (
    input  logic                                CLOCK_50,
    input  logic                                KEY0,
    bus_target_if.target                        bus,
    input  logic [soc_bus_pkg::plic_sources-1:0] irq_sources,
    output logic                                meip_interrupt,
    output logic                                msip_interrupt
);
    import soc_bus_pkg::*;

    logic [prio_w-1:0]       prio [1:plic_sources];
    logic [plic_sources:1]   pending;
    logic [plic_sources:1]   enable [plic_contexts];
    logic [prio_w-1:0]       threshold [plic_contexts];

    // winning id per context, 0 when none
    logic [plic_id_w-1:0]    claim_id [plic_contexts];

    logic [plic_id_w-1:0]    prio_id;
    logic                    prio_hit;
    logic                    pend_hit;
    logic [plic_contexts-1:0] en_hit;
    logic [plic_contexts-1:0] th_hit;
    logic [plic_contexts-1:0] cl_hit;
    logic                    rd_act;
    logic                    wr_act;
    logic [plic_sources:1]   clear_mask;

    assign rd_act = bus.sel && bus.rd_go;
    assign wr_act = bus.sel && bus.wr_go;

    // every access is a single step
    assign bus.ack = bus.sel && (bus.rd_go || bus.wr_go);

    // priority words, one per id from offset 4
    assign prio_id = bus.addr[plic_id_w+1:2];
    assign prio_hit = (bus.addr[1:0] == 2'b00) && (bus.addr >= 4) &&
                      (bus.addr <= plic_sources * 4);
    assign pend_hit = (bus.addr == plic_pending_off);

    // per context register addresses
    always_comb begin
        for (int c = 0; c < plic_contexts; c++) begin
            en_hit[c] = (bus.addr == plic_enable_off + c * plic_enable_step);
            th_hit[c] = (bus.addr == plic_threshold_off + c * plic_threshold_step);
            cl_hit[c] = (bus.addr ==
                         plic_threshold_off + c * plic_threshold_step + plic_claim_off);
        end
    end

    // highest priority strictly above threshold
    // strict compare keeps the lower id on a tie
    always_comb begin
        logic [prio_w-1:0] best;
        for (int c = 0; c < plic_contexts; c++) begin
            best = threshold[c];
            claim_id[c] = '0;
            for (int i = 1; i <= plic_sources; i++) begin
                if (pending[i] && enable[c][i] && prio[i] > best) begin
                    best = prio[i];
                    claim_id[c] = plic_id_w'(i);
                end
            end
        end
    end

    assign meip_interrupt = (claim_id[0] != '0);
    assign msip_interrupt = (claim_id[1] != '0);

    // read mux, unknown offsets read as zero
    always_comb begin
        bus.rdata = '0;
        if (prio_hit) begin
            bus.rdata[prio_w-1:0] = prio[prio_id];
        end
        if (pend_hit) begin
            bus.rdata[plic_sources:1] = pending;
        end
        for (int c = 0; c < plic_contexts; c++) begin
            if (en_hit[c]) begin
                bus.rdata[plic_sources:1] = enable[c];
            end
            if (th_hit[c]) begin
                bus.rdata[prio_w-1:0] = threshold[c];
            end
            if (cl_hit[c]) begin
                bus.rdata[plic_id_w-1:0] = claim_id[c];
            end
        end
    end

    // claim read drops the winner's pending bit
    // id 0 clears nothing
    always_comb begin
        clear_mask = '0;
        for (int c = 0; c < plic_contexts; c++) begin
            if (rd_act && cl_hit[c] && claim_id[c] != '0) begin
                clear_mask[claim_id[c]] = 1'b1;
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 1; i <= plic_sources; i++) begin
                prio[i] <= '0;
            end
            pending <= '0;
            for (int c = 0; c < plic_contexts; c++) begin
                enable[c] <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // level sources keep setting pending
            pending <= (pending & ~clear_mask) | irq_sources;
            if (wr_act) begin
                if (prio_hit) begin
                    prio[prio_id] <= bus.wdata[prio_w-1:0];
                end
                for (int c = 0; c < plic_contexts; c++) begin
                    if (en_hit[c]) begin
                        enable[c] <= bus.wdata[plic_sources:1];
                    end
                    if (th_hit[c]) begin
                        threshold[c] <= bus.wdata[prio_w-1:0];
                    end
                end
            end
        end
    end

endmodule

/* hdl/bus_responder.sv */
module bus_responder (
    input  logic                             CLOCK_50,
    input  logic                             KEY0,
    input  logic [soc_bus_pkg::addr_w-1:0]   bus_address,
    input  logic [soc_bus_pkg::data_w-1:0]   bus_write_data,
    input  logic [2:0]                       bus_ls_type,
    input  logic                             bus_read_enable,
    input  logic                             bus_write_enable,
    output logic [soc_bus_pkg::data_w-1:0]   bus_read_data,
    output logic                             bus_read_done,
    output logic                             bus_write_done,
    bus_target_if.responder                  ram_bus,
    bus_target_if.responder                  plic_bus
);
    import soc_bus_pkg::*;

    logic              ram_hit;
    logic              plic_hit;
    logic              rd_step;
    logic              wr_step;
    logic              tgt_ack;
    logic [data_w-1:0] tgt_rdata;

    // one decode shared by both targets
    assign ram_hit = (bus_address >= ram_base) && (bus_address < ram_base + ram_bytes);
    assign plic_hit = (bus_address >= plic_base) && (bus_address < plic_base + plic_size);

    // access in flight once the strobe is gone
    assign rd_step = !bus_read_done && !bus_read_enable;
    assign wr_step = !bus_write_done && !bus_write_enable;

    assign ram_bus.sel = ram_hit;
    assign ram_bus.rd_go = rd_step && ram_hit;
    assign ram_bus.wr_go = wr_step && ram_hit;
    assign ram_bus.addr = bus_address - ram_base;
    assign ram_bus.wdata = bus_write_data;
    assign ram_bus.ls_type = bus_ls_type;

    assign plic_bus.sel = plic_hit;
    assign plic_bus.rd_go = rd_step && plic_hit;
    assign plic_bus.wr_go = wr_step && plic_hit;
    assign plic_bus.addr = bus_address - plic_base;
    assign plic_bus.wdata = bus_write_data;
    assign plic_bus.ls_type = bus_ls_type;

    // unmapped address completes at once with zero
    always_comb begin
        if (ram_hit) begin
            tgt_ack = ram_bus.ack;
            tgt_rdata = ram_bus.rdata;
        end else if (plic_hit) begin
            tgt_ack = plic_bus.ack;
            tgt_rdata = plic_bus.rdata;
        end else begin
            tgt_ack = 1'b1;
            tgt_rdata = '0;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bus_read_done <= 1'b1;
            bus_write_done <= 1'b1;
            bus_read_data <= '0;
        end else begin
            // strobe drops done for the next cycle
            if (bus_read_enable) begin
                bus_read_done <= 1'b0;
            end
            if (bus_write_enable) begin
                bus_write_done <= 1'b0;
            end
            // data valid from the edge that raises done
            if (rd_step && tgt_ack) begin
                bus_read_data <= tgt_rdata;
                bus_read_done <= 1'b1;
            end
            if (wr_step && tgt_ack) begin
                bus_write_done <= 1'b1;
            end
        end
    end

endmodule

/* hdl/soc_bus_top.sv */
module soc_bus_top (
    input  logic                                 CLOCK_50,
    input  logic                                 KEY0,
    input  logic [soc_bus_pkg::addr_w-1:0]       bus_address,
    input  logic [soc_bus_pkg::data_w-1:0]       bus_write_data,
    input  logic [2:0]                           bus_ls_type,
    input  logic                                 bus_read_enable,
    input  logic                                 bus_write_enable,
    input  logic [soc_bus_pkg::plic_sources-1:0] irq_sources,
    output logic [soc_bus_pkg::data_w-1:0]       bus_read_data,
    output logic                                 bus_read_done,
    output logic                                 bus_write_done,
    output logic                                 meip_interrupt,
    output logic                                 msip_interrupt
);

    // one link per target
    bus_target_if ram_bus ();
    bus_target_if plic_bus ();

    bus_responder u_responder (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_bus          (ram_bus.responder),
        .plic_bus         (plic_bus.responder)
    );

    ram_port u_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus.target)
    );

    // level interrupt sources straight from the top-level pins
    plic_regs u_plic (
        .CLOCK_50       (CLOCK_50),
        .KEY0           (KEY0),
        .bus            (plic_bus.target),
        .irq_sources    (irq_sources),
        .meip_interrupt (meip_interrupt),
        .msip_interrupt (msip_interrupt)
    );

endmodule

/* verification/soc_bus_assertions.sv */
module soc_bus_assertions (
    input logic                               CLOCK_50,
    input logic                               KEY0,
    input logic [soc_bus_pkg::addr_w-1:0]     bus_address,
    input logic [2:0]                         bus_ls_type,
    input logic                               bus_read_enable,
    input logic                               bus_write_enable,
    input logic [soc_bus_pkg::data_w-1:0]     bus_read_data,
    input logic                               bus_read_done,
    input logic                               bus_write_done,
    input logic                               meip_interrupt,
    input logic                               msip_interrupt
);
    import soc_bus_pkg::*;

    // failed assertion count, read by the testbench at the end
    int fail_count;

    // ld / sd into the RAM window take the extra beat
    logic ram_double;
    assign ram_double = (bus_ls_type == ls_ld) && (bus_address >= ram_base) &&
                        (bus_address < ram_base + ram_bytes);

    // idle outputs through reset and on the first cycle out of it
    a_reset_state: assert property (@(posedge CLOCK_50)
        !KEY0 |=> bus_read_done && bus_write_done &&
            (bus_read_data == '0) && !meip_interrupt && !msip_interrupt)
    else begin
        $error("outputs not idle around reset");
        fail_count++;
    end

    a_read_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable && !ram_double |=> !bus_read_done ##1 bus_read_done)
    else begin
        $error("single step read done off schedule");
        fail_count++;
    end

    a_read_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_read_enable && ram_double |=> !bus_read_done ##1 !bus_read_done ##1 bus_read_done)
    else begin
        $error("ld read done off schedule");
        fail_count++;
    end

    a_write_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && !ram_double |=> !bus_write_done ##1 bus_write_done)
    else begin
        $error("single step write done off schedule");
        fail_count++;
    end

    a_write_double: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        bus_write_enable && ram_double |=> !bus_write_done ##1 !bus_write_done ##1
            bus_write_done)
    else begin
        $error("sd write done off schedule");
        fail_count++;
    end

endmodule

bind soc_bus_top soc_bus_assertions u_assertions (.*);

/* verification/soc_bus_tb.sv */
module soc_bus_tb;
    import soc_bus_pkg::*;

    // rough run time of all tests, doubled for the watchdog
    localparam int test_cycles = 2000;
    localparam int timeout_cycles = 2 * test_cycles;
    // RAM bytes under test, from the RAM base
    localparam int region_bytes = 128;
    localparam int round_trips = 24;

    localparam logic [addr_w-1:0] th0 = plic_base + plic_threshold_off;
    localparam logic [addr_w-1:0] th1 = th0 + plic_threshold_step;
    localparam logic [addr_w-1:0] cl0 = th0 + plic_claim_off;
    localparam logic [addr_w-1:0] cl1 = th1 + plic_claim_off;

    logic              CLOCK_50;
    logic              KEY0;
    logic [addr_w-1:0] bus_address;
    logic [data_w-1:0] bus_write_data;
    logic [2:0]        bus_ls_type;
    logic              bus_read_enable;
    logic              bus_write_enable;
    logic [4:0]        irq_sources;
    logic [data_w-1:0] bus_read_data;
    logic              bus_read_done;
    logic              bus_write_done;
    logic              meip_interrupt;
    logic              msip_interrupt;

    // expected RAM contents, one entry per byte
    logic [7:0] shadow [region_bytes];
    int value_errors;
    int cycle_count;
    int seed;

    soc_bus_top DUT (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .irq_sources      (irq_sources),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip_interrupt   (meip_interrupt),
        .msip_interrupt   (msip_interrupt)
    );

    always #50 CLOCK_50 = ~CLOCK_50;

    // watchdog
    always @(posedge CLOCK_50) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: tests still running after %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected)
        else begin
            value_errors++;
            $display("error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one strobe, then wait for the matching done level
    task automatic bus_access(input logic is_write, input logic [addr_w-1:0] addr,
                              input logic [2:0] code, input logic [data_w-1:0] wdata,
                              output logic [data_w-1:0] rdata);
        @(posedge CLOCK_50);
        bus_address <= addr;
        bus_ls_type <= code;
        bus_write_data <= wdata;
        bus_write_enable <= is_write;
        bus_read_enable <= !is_write;
        @(posedge CLOCK_50);
        bus_write_enable <= 1'b0;
        bus_read_enable <= 1'b0;
        @(posedge CLOCK_50);
        while (is_write ? !bus_write_done : !bus_read_done) begin
            @(posedge CLOCK_50);
        end
        rdata = bus_read_data;
    endtask

    task automatic store_bytes(input int offset, input logic [2:0] code,
                               input logic [63:0] data);
        int nbytes;
        logic [63:0] unused;
        nbytes = 1 << code[1:0];
        for (int i = 0; i < nbytes; i++) begin
            shadow[offset + i] = data[8*i +: 8];
        end
        bus_access(1'b1, ram_base + offset, code, data, unused);
    endtask

    // little endian bytes, sign-extended unless the unsigned bit is set
    function automatic logic [63:0] expected_load(input int offset, input logic [2:0] code);
        int nbytes;
        logic [63:0] value;
        logic neg;
        nbytes = 1 << code[1:0];
        value = '0;
        for (int i = 0; i < nbytes; i++) begin
            value[8*i +: 8] = shadow[offset + i];
        end
        neg = !code[2] && value[8*nbytes-1];
        for (int i = nbytes; i < 8; i++) begin
            value[8*i +: 8] = neg ? 8'hff : 8'h00;
        end
        return value;
    endfunction

    task automatic plic_write(input logic [addr_w-1:0] addr, input logic [63:0] data);
        logic [63:0] unused;
        bus_access(1'b1, addr, 3'b010, data, unused);
    endtask

    task automatic plic_read(input string name, input logic [addr_w-1:0] addr,
                             input logic [63:0] expected);
        logic [63:0] got;
        bus_access(1'b0, addr, 3'b010, '0, got);
        check_value(name, expected, got);
    endtask

    initial begin
        logic [63:0] got;
        logic [63:0] data;
        logic [2:0]  code;
        int          offset;
        int          load_off;
        CLOCK_50 = 1'b0;
        KEY0 = 1'b0;
        bus_address = '0;
        bus_write_data = '0;
        bus_ls_type = '0;
        bus_read_enable = 1'b0;
        bus_write_enable = 1'b0;
        irq_sources = '0;
        value_errors = 0;
        cycle_count = 0;
        seed = 46;
        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        // known contents first, pattern from the full byte offset
        for (int a = 0; a < region_bytes; a += 8) begin
            store_bytes(a, 3'b011, {~32'(a), 32'(a)} ^ 64'h5a5a_c3c3_1234_8765);
        end

        // random store, then every load type at the matching alignment
        for (int n = 0; n < round_trips; n++) begin
            code = 3'($random(seed) & 3);
            offset = ($random(seed) & (region_bytes - 1)) & ~((1 << code) - 1);
            data = {32'($random(seed)), 32'($random(seed))};
            store_bytes(offset, code, data);
            for (int c = 0; c < 7; c++) begin
                load_off = offset & ~((1 << c[1:0]) - 1);
                bus_access(1'b0, ram_base + load_off, 3'(c), '0, got);
                check_value($sformatf("ram load %0d at %0h", c, load_off),
                            expected_load(load_off, 3'(c)), got);
            end
        end

        // nothing mapped here
        bus_access(1'b0, 64'h0000_0000_8000_0000, 3'b010, '0, got);
        check_value("unmapped read", 64'h0, got);

        // priorities 2 5 5 1 3 for ids 1 to 5
        plic_write(plic_base + 4, 2);
        plic_write(plic_base + 8, 5);
        plic_write(plic_base + 12, 5);
        plic_write(plic_base + 16, 1);
        plic_write(plic_base + 20, 3);
        plic_read("priority id 2", plic_base + 8, 5);
        // ctx0 takes ids 1-3, ctx1 ids 4-5
        plic_write(plic_base + plic_enable_off, 64'h0e);
        plic_write(plic_base + plic_enable_off + plic_enable_step, 64'h30);
        plic_write(th0, 1);
        plic_write(th1, 3);
        check_value("meip idle", 1'b0, meip_interrupt);
        check_value("msip idle", 1'b0, msip_interrupt);

        // ids 2 3 5 high, pending follows on the next edge
        @(posedge CLOCK_50);
        irq_sources <= 5'b10110;
        repeat (2) @(posedge CLOCK_50);
        check_value("meip tie above threshold", 1'b1, meip_interrupt);
        // id 5 priority equals threshold
        check_value("msip at threshold", 1'b0, msip_interrupt);
        irq_sources <= 5'b11110;
        plic_write(th1, 2);
        check_value("msip above threshold", 1'b1, msip_interrupt);

        // drop sources so claims stick
        @(posedge CLOCK_50);
        irq_sources <= '0;
        plic_read("claim ctx0 tie", cl0, 2);
        plic_read("pending after claim", plic_base + plic_pending_off, 64'h38);
        plic_read("claim ctx0 next", cl0, 3);
        plic_read("claim ctx0 empty", cl0, 0);
        check_value("meip after claims", 1'b0, meip_interrupt);
        plic_read("claim ctx1", cl1, 5);
        plic_read("claim ctx1 empty", cl1, 0);
        check_value("msip after claims", 1'b0, msip_interrupt);
        plic_read("pending left", plic_base + plic_pending_off, 64'h10);

        // let the last bound checks finish
        repeat (4) @(posedge CLOCK_50);
        $display("value errors: %0d, protocol errors: %0d", value_errors,
                 DUT.u_assertions.fail_count);
        if (value_errors == 0 && DUT.u_assertions.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
hdl/soc_bus_pkg.sv
hdl/bus_target_if.sv
hdl/ram_port.sv
hdl/plic_regs.sv
hdl/bus_responder.sv
hdl/soc_bus_top.sv
verification/soc_bus_assertions.sv
verification/soc_bus_tb.sv
